/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = pool_top_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* rtl/bram_sdp.sv */
// Simple dual-port RAM, one write port and one registered read port
`timescale 1ns/1ps

module bram_sdp #(
    parameter int DEPTH = 784,
    parameter int WIDTH = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [WIDTH-1:0]         wdata,
    input  logic                     re,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0]         rdata
);

    logic [WIDTH-1:0] mem [0:DEPTH-1];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read data lands one cycle after re
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

    // Address width rounds up, so the top codes are outside the array
    a_waddr_in_range: assert property (@(posedge clk) we |-> (int'(waddr) < DEPTH))
        else $error("bram_sdp write beyond depth %0d", DEPTH);

endmodule

/* rtl/frame_controller.sv */
// Controller FSM that sequences frame load, pooling and streaming
`timescale 1ns/1ps

module frame_controller import pool_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic frame_loaded,
    input  logic pool_done,
    input  logic stream_done,
    output logic load_en,
    output logic pool_start,
    output logic stream_start
);

    ctrl_state_t state;

    // Loader only runs while the FSM waits for a frame
    assign load_en = (state == ST_LOAD);

    // ============================================================
    // State and start pulses
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ST_LOAD;
            pool_start   <= 1'b0;
            stream_start <= 1'b0;
        end else begin
            pool_start   <= 1'b0;
            stream_start <= 1'b0;
            case (state)
                ST_LOAD: begin
                    if (frame_loaded) begin
                        state      <= ST_POOL;
                        pool_start <= 1'b1;
                    end
                end
                ST_POOL: begin
                    if (pool_done) begin
                        state        <= ST_STREAM;
                        stream_start <= 1'b1;
                    end
                end
                ST_STREAM: begin
                    // Next frame may start once the last value is gone
                    if (stream_done) begin
                        state <= ST_LOAD;
                    end
                end
                default: state <= ST_LOAD;
            endcase
        end
    end

endmodule

/* rtl/frame_loader.sv */
// Byte stream acceptance, quantisation LUT and raster write into the frame buffer
`timescale 1ns/1ps
`include "pool_config.svh"

module frame_loader import pool_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        load_en,
    input  logic        in_valid,
    input  byte_t       in_data,
    output logic        in_ready,
    output logic        wr_en,
    output frame_addr_t wr_addr,
    output pixel_t      wr_data,
    output logic        frame_loaded
);

    localparam frame_addr_t LAST_PIX = frame_addr_t'(`FRAME_DEPTH - 1);

    pixel_t      quant_lut [0:255];
    frame_addr_t pix_cnt;
    logic        accept;

    // Byte k maps to round(k / 255 * 2^FRAC_BITS)
    initial begin : init_lut
        int k;
        int v;
        for (k = 0; k < 256; k++) begin
            v = ((k << `FRAC_BITS) + 127) / 255;
            quant_lut[k] = pixel_t'(v);
        end
    end

    // Closed while the frame-complete pulse is out, so no byte slips in
    assign in_ready = load_en && !frame_loaded;
    assign accept   = in_valid && in_ready;

    // ============================================================
    // Raster counter
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            pix_cnt      <= '0;
            wr_en        <= 1'b0;
            frame_loaded <= 1'b0;
        end else begin
            wr_en        <= accept;
            frame_loaded <= 1'b0;
            if (accept) begin
                if (pix_cnt == LAST_PIX) begin
                    pix_cnt      <= '0;
                    frame_loaded <= 1'b1;
                end else begin
                    pix_cnt <= pix_cnt + 1'b1;
                end
            end
        end
    end

    // Quantised pixel goes to the buffer on the following edge
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_addr <= pix_cnt;
            wr_data <= quant_lut[in_data];
        end
    end

    // Outside the load phase the loader sits idle at the start of a frame
    a_load_only: assert property (@(posedge clk) disable iff (reset)
        !load_en |-> (pix_cnt == '0 && !wr_en))
        else $error("loader active outside the load phase");

endmodule

/* rtl/maxpool_engine.sv */
// 2x2 max-pool engine, reads the frame buffer and fills the pool buffer
`timescale 1ns/1ps
`include "pool_config.svh"

module maxpool_engine import pool_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    output logic        rd_en,
    output frame_addr_t rd_addr,
    input  pixel_t      rd_data,
    output logic        wr_en,
    output pool_addr_t  wr_addr,
    output pixel_t      wr_data,
    output logic        done
);

    localparam int CNT_W = $clog2(`POOLED);
    localparam logic [CNT_W-1:0] LAST_WIN = CNT_W'(`POOLED - 1);
    localparam frame_addr_t COL_STEP = frame_addr_t'(`POOL);
    localparam frame_addr_t ROW_STEP = frame_addr_t'(`IMG_SIZE);
    // From the last window of a row to the first of the next window row
    localparam frame_addr_t ROW_JUMP = frame_addr_t'(`POOL + `IMG_SIZE * (`POOL - 1));
    localparam pool_addr_t LAST_OUT = pool_addr_t'(`POOL_DEPTH - 1);

    logic             busy;
    logic             reading;
    logic [1:0]       phase;
    logic [1:0]       phase_q;
    logic [CNT_W-1:0] win_col;
    logic [CNT_W-1:0] win_row;
    frame_addr_t      tl_addr;
    logic             rd_valid_q;
    pixel_t           run_max;
    pixel_t           win_max;

    // Phase bit 0 picks the column, bit 1 the row inside the window
    assign rd_en   = reading;
    assign rd_addr = tl_addr + (phase[1] ? ROW_STEP : '0) + frame_addr_t'(phase[0]);

    // First sample of a window restarts the maximum
    assign win_max = (phase_q == 2'd0 || rd_data > run_max) ? rd_data : run_max;

    // ============================================================
    // Window walk and write-back control
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            reading    <= 1'b0;
            phase      <= 2'd0;
            win_col    <= '0;
            win_row    <= '0;
            tl_addr    <= '0;
            rd_valid_q <= 1'b0;
            wr_en      <= 1'b0;
            wr_addr    <= '0;
            done       <= 1'b0;
        end else begin
            rd_valid_q <= reading;
            wr_en      <= rd_valid_q && (phase_q == 2'd3);
            done       <= wr_en && (wr_addr == LAST_OUT);
            if (wr_en) begin
                wr_addr <= wr_addr + 1'b1;
            end
            if (start && !busy) begin
                busy    <= 1'b1;
                reading <= 1'b1;
                phase   <= 2'd0;
                win_col <= '0;
                win_row <= '0;
                tl_addr <= '0;
                wr_addr <= '0;
            end else if (reading) begin
                phase <= phase + 1'b1;
                if (phase == 2'd3) begin
                    if (win_col == LAST_WIN) begin
                        win_col <= '0;
                        tl_addr <= tl_addr + ROW_JUMP;
                        if (win_row == LAST_WIN) begin
                            reading <= 1'b0;
                        end else begin
                            win_row <= win_row + 1'b1;
                        end
                    end else begin
                        win_col <= win_col + 1'b1;
                        tl_addr <= tl_addr + COL_STEP;
                    end
                end
            end
            if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // Returning samples, tracked one cycle behind the reads
    always_ff @(posedge clk) begin
        phase_q <= phase;
        if (rd_valid_q) begin
            run_max <= win_max;
            if (phase_q == 2'd3) begin
                wr_data <= win_max;
            end
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (reset) start |-> !busy)
        else $error("pool start while engine busy");

endmodule

/* rtl/pool_config.svh */
// Frame geometry, pooling factor and fixed-point format of the pixels
`ifndef POOL_CONFIG_SVH
`define POOL_CONFIG_SVH

// Input frame side in pixels
`define IMG_SIZE 28

// Pooling window side
`define POOL 2

// Fixed-point pixel format
`define DATA_WIDTH 16
`define FRAC_BITS 7

// Derived sizes
`define FRAME_DEPTH (`IMG_SIZE * `IMG_SIZE)
`define POOLED (`IMG_SIZE / `POOL)
`define POOL_DEPTH (`POOLED * `POOLED)

`endif

/* rtl/pool_pkg.sv */
// Shared types: input byte, fixed-point pixel, buffer addresses, controller state
`include "pool_config.svh"

package pool_pkg;

    // ============================================================
    // Data and address types
    // ============================================================
    typedef logic [7:0] byte_t;
    typedef logic signed [`DATA_WIDTH-1:0] pixel_t;
    typedef logic [$clog2(`FRAME_DEPTH)-1:0] frame_addr_t;
    typedef logic [$clog2(`POOL_DEPTH)-1:0] pool_addr_t;

    // ============================================================
    // Controller states
    // ============================================================
    typedef enum logic [1:0] {
        ST_LOAD,
        ST_POOL,
        ST_STREAM
    } ctrl_state_t;

endpackage

/* rtl/pool_streamer.sv */
// Pool buffer reader with a valid/ready output stream and a last marker
`timescale 1ns/1ps
`include "pool_config.svh"

module pool_streamer import pool_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    output logic       rd_en,
    output pool_addr_t rd_addr,
    input  pixel_t     rd_data,
    output logic       out_valid,
    input  logic       out_ready,
    output pixel_t     out_data,
    output logic       out_last,
    output logic       done
);

    localparam pool_addr_t LAST_ADDR = pool_addr_t'(`POOL_DEPTH - 1);

    // Read issued last cycle, data is on rd_data now
    logic rd_pend;

    // ============================================================
    // One read per output transfer
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_en     <= 1'b0;
            rd_addr   <= '0;
            rd_pend   <= 1'b0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            done      <= 1'b0;
        end else begin
            rd_en   <= 1'b0;
            rd_pend <= rd_en;
            done    <= 1'b0;
            if (start) begin
                rd_en   <= 1'b1;
                rd_addr <= '0;
            end
            if (rd_pend) begin
                out_valid <= 1'b1;
                out_last  <= (rd_addr == LAST_ADDR);
            end else if (out_valid && out_ready) begin
                out_valid <= 1'b0;
                out_last  <= 1'b0;
                if (out_last) begin
                    done <= 1'b1;
                end else begin
                    rd_en   <= 1'b1;
                    rd_addr <= rd_addr + 1'b1;
                end
            end
        end
    end

    // Output register, loaded only when fresh read data arrives
    always_ff @(posedge clk) begin
        if (rd_pend) begin
            out_data <= rd_data;
        end
    end

    a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last)))
        else $error("output changed while stalled");

endmodule

/* rtl/pool_top.sv */
// Pooling front end top level: loader, frame and pool buffers, engine, streamer, FSM
`timescale 1ns/1ps
`include "pool_config.svh"

module pool_top import pool_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   in_valid,
    input  byte_t  in_data,
    output logic   in_ready,
    output logic   out_valid,
    input  logic   out_ready,
    output pixel_t out_data,
    output logic   out_last
);

    // Sequencing
    logic load_en;
    logic frame_loaded;
    logic pool_start;
    logic pool_done;
    logic stream_start;
    logic stream_done;

    // Frame buffer ports
    logic        fb_we;
    frame_addr_t fb_waddr;
    pixel_t      fb_wdata;
    logic        fb_re;
    frame_addr_t fb_raddr;
    pixel_t      fb_rdata;

    // Pool buffer ports
    logic       pb_we;
    pool_addr_t pb_waddr;
    pixel_t     pb_wdata;
    logic       pb_re;
    pool_addr_t pb_raddr;
    pixel_t     pb_rdata;

    // ============================================================
    // Stages
    // ============================================================
    frame_loader u_loader (
        .clk          (clk),
        .reset        (reset),
        .load_en      (load_en),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_ready     (in_ready),
        .wr_en        (fb_we),
        .wr_addr      (fb_waddr),
        .wr_data      (fb_wdata),
        .frame_loaded (frame_loaded)
    );

    bram_sdp #(.DEPTH(`FRAME_DEPTH), .WIDTH(`DATA_WIDTH)) u_frame_buf (
        .clk   (clk),
        .we    (fb_we),
        .waddr (fb_waddr),
        .wdata (fb_wdata),
        .re    (fb_re),
        .raddr (fb_raddr),
        .rdata (fb_rdata)
    );

    maxpool_engine u_engine (
        .clk     (clk),
        .reset   (reset),
        .start   (pool_start),
        .rd_en   (fb_re),
        .rd_addr (fb_raddr),
        .rd_data (fb_rdata),
        .wr_en   (pb_we),
        .wr_addr (pb_waddr),
        .wr_data (pb_wdata),
        .done    (pool_done)
    );

    bram_sdp #(.DEPTH(`POOL_DEPTH), .WIDTH(`DATA_WIDTH)) u_pool_buf (
        .clk   (clk),
        .we    (pb_we),
        .waddr (pb_waddr),
        .wdata (pb_wdata),
        .re    (pb_re),
        .raddr (pb_raddr),
        .rdata (pb_rdata)
    );

    pool_streamer u_streamer (
        .clk       (clk),
        .reset     (reset),
        .start     (stream_start),
        .rd_en     (pb_re),
        .rd_addr   (pb_raddr),
        .rd_data   (pb_rdata),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last),
        .done      (stream_done)
    );

    frame_controller u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .frame_loaded (frame_loaded),
        .pool_done    (pool_done),
        .stream_done  (stream_done),
        .load_en      (load_en),
        .pool_start   (pool_start),
        .stream_start (stream_start)
    );

endmodule

/* sim.f */
+incdir+rtl
rtl/pool_pkg.sv
rtl/bram_sdp.sv
rtl/frame_loader.sv
rtl/maxpool_engine.sv
rtl/pool_streamer.sv
rtl/frame_controller.sv
rtl/pool_top.sv
tb/pool_top_tb.sv

/* tb/pool_top_tb.sv */
// Testbench for the pooling front end: random byte frames, reference model,
// output checker, stall and handshake checks, timeout
`timescale 1ns/1ps
`include "pool_config.svh"

module pool_top_tb import pool_pkg::*; ();

    localparam int TOTAL_BYTES = 2 * `FRAME_DEPTH;
    localparam int TOTAL_OUT   = 2 * `POOL_DEPTH;
    // Two frames of roughly 3100 cycles each, with margin
    localparam int MAX_CYCLES  = 8000;

    logic   clk = 1'b0;
    logic   reset = 1'b1;
    logic   in_valid = 1'b0;
    byte_t  in_data = '0;
    logic   in_ready;
    logic   out_valid;
    logic   out_ready = 1'b0;
    pixel_t out_data;
    logic   out_last;

    integer seed = 77;
    byte_t  frame_bytes [0:TOTAL_BYTES-1];
    pixel_t exp_q [$];
    int     in_idx = 0;
    int     in_acc = 0;
    int     out_cnt = 0;
    int     cycle_cnt = 0;
    int     val_errs = 0;
    int     proto_errs = 0;
    logic   reset_q = 1'b0;
    logic   frame_busy = 1'b0;
    logic   prev_stall = 1'b0;
    pixel_t prev_data;
    logic   prev_last;

    pool_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last)
    );

    always #5 clk = ~clk;

    // ============================================================
    // Reference model
    // ============================================================
    // Round half up of b * 2^FRAC_BITS / 255
    function automatic pixel_t quantise(input byte_t b);
        int num;
        num = 2 * (int'(b) << `FRAC_BITS) + 255;
        return pixel_t'(num / 510);
    endfunction

    function automatic pixel_t window_max(input int base, input int pr, input int pc);
        pixel_t m;
        pixel_t v;
        m = '0;
        for (int dr = 0; dr < `POOL; dr++) begin
            for (int dc = 0; dc < `POOL; dc++) begin
                v = quantise(frame_bytes[base + (pr * `POOL + dr) * `IMG_SIZE
                                         + pc * `POOL + dc]);
                if ((dr == 0 && dc == 0) || v > m) begin
                    m = v;
                end
            end
        end
        return m;
    endfunction

    task automatic build_expected();
        for (int f = 0; f < 2; f++) begin
            for (int pr = 0; pr < `POOLED; pr++) begin
                for (int pc = 0; pc < `POOLED; pc++) begin
                    exp_q.push_back(window_max(f * `FRAME_DEPTH, pr, pc));
                end
            end
        end
    endtask

    task automatic print_summary();
        $display("Summary: value errors %0d, protocol errors %0d, outputs %0d of %0d",
                 val_errs, proto_errs, out_cnt, TOTAL_OUT);
    endtask

    // ============================================================
    // Stimulus
    // ============================================================
    always @(posedge clk) begin
        logic [31:0] rnd;
        rnd = $random(seed);
        out_ready <= rnd[0];
        if (reset) begin
            in_valid <= 1'b0;
        end else begin
            if (in_valid && in_ready) begin
                in_idx++;
            end
            // A byte on offer stays put until it is taken
            if (!in_valid || in_ready) begin
                if (in_idx < TOTAL_BYTES && rnd[2:1] != 2'b00) begin
                    in_valid <= 1'b1;
                    in_data  <= frame_bytes[in_idx];
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
    end

    // ============================================================
    // Checker
    // ============================================================
    always @(posedge clk) begin
        pixel_t exp_val;
        logic   exp_last;
        if (reset_q) begin
            assert (!out_valid && in_ready) else begin
                $display("ERROR t=%0t out_valid/in_ready expected 0/1 got %0b/%0b",
                         $time, out_valid, in_ready);
                val_errs++;
            end
        end
        if (!reset) begin
            if (frame_busy) begin
                assert (!in_ready) else begin
                    $display("ERROR t=%0t in_ready expected 0 got %0b", $time, in_ready);
                    val_errs++;
                end
            end
            if (prev_stall) begin
                assert (out_valid) else begin
                    $display("ERROR t=%0t out_valid held expected 1 got %0b",
                             $time, out_valid);
                    val_errs++;
                end
                assert (out_data == prev_data) else begin
                    $display("ERROR t=%0t out_data held expected %0d got %0d",
                             $time, prev_data, out_data);
                    val_errs++;
                end
                assert (out_last == prev_last) else begin
                    $display("ERROR t=%0t out_last held expected %0b got %0b",
                             $time, prev_last, out_last);
                    val_errs++;
                end
            end
            if (in_valid && in_ready) begin
                in_acc++;
                if (in_acc % `FRAME_DEPTH == 0) begin
                    frame_busy = 1'b1;
                end
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Output transferred after all expected values were used up");
                    proto_errs++;
                end else begin
                    exp_val  = exp_q.pop_front();
                    exp_last = (out_cnt % `POOL_DEPTH == `POOL_DEPTH - 1);
                    assert (out_data == exp_val) else begin
                        $display("ERROR t=%0t out_data expected %0d got %0d",
                                 $time, exp_val, out_data);
                        val_errs++;
                    end
                    assert (out_last == exp_last) else begin
                        $display("ERROR t=%0t out_last expected %0b got %0b",
                                 $time, exp_last, out_last);
                        val_errs++;
                    end
                end
                out_cnt++;
                if (out_cnt % `POOL_DEPTH == 0) begin
                    frame_busy = 1'b0;
                end
            end
            prev_stall = out_valid && !out_ready;
            prev_data  = out_data;
            prev_last  = out_last;
        end
        reset_q = reset;
    end

    // ============================================================
    // Timeout and end of run
    // ============================================================
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            print_summary();
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        for (int i = 0; i < TOTAL_BYTES; i++) begin
            frame_bytes[i] = byte_t'($random(seed));
        end
        build_expected();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        wait (out_cnt == TOTAL_OUT);
        // Loader must reopen once the last frame has drained
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (in_acc != TOTAL_BYTES) begin
            $display("Loader accepted %0d bytes instead of %0d", in_acc, TOTAL_BYTES);
            proto_errs++;
        end
        if (out_cnt != TOTAL_OUT || exp_q.size() != 0) begin
            $display("Output count wrong, %0d values seen, %0d still expected",
                     out_cnt, exp_q.size());
            proto_errs++;
        end
        print_summary();
        if (val_errs + proto_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
